//--- Bender.yml
package:
  name: core_io

sources:
  - common/dbus_pkg.sv
  - common/io_map_pkg.sv
  - io_regs/io_byte_reg.sv
  - io_regs/io_regfile.sv
  - dmem_port/dmem_lane_adapter.sv
  - verilog/dbus_responder.sv
  - verilog/core_io_top.sv
  - target: simulation
    files:
      - sim/core_io_props.sv
      - sim/core_io_tb.sv

//--- core_io.f
common/dbus_pkg.sv
common/io_map_pkg.sv
io_regs/io_byte_reg.sv
io_regs/io_regfile.sv
dmem_port/dmem_lane_adapter.sv
verilog/dbus_responder.sv
verilog/core_io_top.sv
sim/core_io_props.sv
sim/core_io_tb.sv

//--- sim/core_io_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_io_tb;
  import dbus_pkg::*;
  import io_map_pkg::*;

  localparam int          MAX_CYCLES = 4000;
  localparam logic [31:0] IO_BASE    = 32'h0000_8000;

  logic        clk;
  logic        rst;
  logic [3:0]  core_id;
  dbus_req_t   dbus_req;
  dbus_rsp_t   dbus_rsp;
  logic        ext_dmem_en;
  logic [7:0]  ext_dmem_wen;
  logic [15:0] ext_dmem_addr;
  logic [63:0] ext_dmem_wr_data;
  logic [63:0] ext_dmem_rd_data;
  logic        ext_dmem_rd_valid;
  desc_t       in_desc;
  logic        in_desc_valid;
  logic        in_desc_taken;
  logic [4:0]  recv_dram_tag;
  logic        recv_dram_tag_valid;
  desc_t       data_desc;
  logic        data_desc_valid;
  desc_t       dram_wr_addr;
  logic        data_desc_ready;

  logic [63:0] mem [256];
  word_t       exp_rsp [$];
  logic [31:0] seed;
  int          cycles;
  int          checks;
  int          err_count;

  core_io_top i_core_io_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Byte enables of the 64-bit line for a bus store
  function automatic logic [7:0] line_mask(input logic [31:0] addr, input logic [1:0] size);
    logic [7:0] m;
    int         first;
    int         n;
    m     = '0;
    first = addr[2:0];
    n     = (size == 2'd0) ? 1 : (size == 2'd1) ? 2 : 4;
    if (size == 2'd2) begin
      first = {addr[2], 2'b00};
    end
    for (int i = 0; i < n; i++) begin
      m[first + i] = 1'b1;
    end
    return m;
  endfunction

  function automatic logic [63:0] line_data(input logic [31:0] addr, input word_t wdata);
    return addr[2] ? {wdata, 32'h0} : {32'h0, wdata};
  endfunction

  function automatic word_t mem_word(input logic [31:0] addr);
    logic [63:0] line;
    line = mem[addr[10:3]];
    return addr[2] ? line[63:32] : line[31:0];
  endfunction

  // Flags after one cycle, a set wins over a clear
  function automatic logic [31:0] flag_next(input logic [31:0] cur,
                                            input logic [31:0] set,
                                            input logic [31:0] clr);
    logic [31:0] nxt;
    nxt    = (cur & ~clr) | set;
    nxt[0] = 1'b0;
    return nxt;
  endfunction

  // Status word, descriptor valid in bit 0 and ready in bit 8
  function automatic word_t status_word(input logic desc_valid, input logic ready);
    return {23'd0, ready, 7'd0, desc_valid};
  endfunction

  //////////////////////////////////////////////////
  // Memory model and checkers

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0] * 32'h9E37_79B9, ~(i[7:0] * 32'h85EB_CA6B)};
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      ext_dmem_rd_valid <= 1'b0;
    end else begin
      ext_dmem_rd_valid <= ext_dmem_en && (ext_dmem_wen == '0);
      if (ext_dmem_en && (ext_dmem_wen == '0)) begin
        ext_dmem_rd_data <= mem[ext_dmem_addr[10:3]];
      end
      for (int b = 0; b < 8; b++) begin
        if (ext_dmem_en && ext_dmem_wen[b]) begin
          mem[ext_dmem_addr[10:3]][b*8 +: 8] <= ext_dmem_wr_data[b*8 +: 8];
        end
      end
    end
  end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      err_count++;
      $display("** Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // Compares every response against the oldest pending read
  always begin
    @(posedge clk);
    #2;
    if (!rst && dbus_rsp.valid) begin
      assert (exp_rsp.size() != 0) else begin
        err_count++;
        $display("Response arrived with no read pending");
      end
      if (exp_rsp.size() != 0) begin
        check_eq("dbus_rsp.rdata", dbus_rsp.rdata, exp_rsp.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles, the DUT stopped responding", cycles);
      $display("Checks: %0d, errors: %0d", checks, err_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Bus tasks

  task automatic bus_write(input logic [31:0] addr, input word_t data, input logic [1:0] size);
    @(negedge clk);
    dbus_req = '{valid: 1'b1, wr: 1'b1, addr: addr, wdata: data, size: size};
    #1;
    if (!addr[15]) begin
      check_eq("ext_dmem_en", ext_dmem_en, 1'b1);
      check_eq("ext_dmem_addr", ext_dmem_addr, addr[15:0]);
      check_eq("ext_dmem_wen", ext_dmem_wen, line_mask(addr, size));
      check_eq("ext_dmem_wr_data", ext_dmem_wr_data, line_data(addr, data));
    end
    @(negedge clk);
    dbus_req = '0;
  endtask

  task automatic bus_read(input logic [31:0] addr, input word_t exp);
    @(negedge clk);
    dbus_req = '{valid: 1'b1, wr: 1'b0, addr: addr, wdata: '0, size: 2'd2};
    exp_rsp.push_back(exp);
    @(negedge clk);
    dbus_req = '0;
    while (exp_rsp.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic tag_pulse(input logic [4:0] tag);
    @(negedge clk);
    recv_dram_tag       = tag;
    recv_dram_tag_valid = 1'b1;
    @(negedge clk);
    recv_dram_tag_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Stimulus

  initial begin
    logic [31:0] addr;
    logic [1:0]  size;
    desc_t       exp_desc;
    desc_t       exp_dram;
    logic [31:0] exp_flags;

    rst = 1'b1;
    core_id = 4'hB;
    dbus_req = '0;
    ext_dmem_rd_data = '0;
    ext_dmem_rd_valid = 1'b0;
    in_desc = '0;
    in_desc_valid = 1'b0;
    recv_dram_tag = '0;
    recv_dram_tag_valid = 1'b0;
    data_desc_ready = 1'b0;
    seed = 32'h6615;
    cycles = 0;
    checks = 0;
    err_count = 0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // Random stores, then random loads
    for (int i = 0; i < 40; i++) begin
      seed = lcg_next(seed);
      size = seed[31:30] % 3;
      addr = {21'd0, seed[10:0]};
      addr = (size == 2'd2) ? {addr[31:2], 2'b00} : (size == 2'd1) ? {addr[31:1], 1'b0} : addr;
      seed = lcg_next(seed);
      bus_write(addr, seed, size);
    end
    for (int i = 0; i < 40; i++) begin
      seed = lcg_next(seed);
      addr = {21'd0, seed[10:2], 2'b00};
      @(negedge clk);
      bus_read(addr, mem_word(addr));
    end

    // Outgoing descriptor under back-pressure
    exp_desc = {32'hC0DE_F00D, 8'h44, 8'h33, 8'h22, 8'h11};
    exp_dram = 64'h0000_0012_3456_7800;
    for (int b = 0; b < 4; b++) begin
      bus_write(IO_BASE + b, {4{exp_desc[b*8 +: 8]}}, 2'd0);
    end
    bus_write(IO_BASE + 32'h04, exp_desc[63:32], 2'd2);
    bus_write(IO_BASE + 32'h08, exp_dram[31:0], 2'd2);
    bus_write(IO_BASE + 32'h0C, exp_dram[63:32], 2'd2);
    bus_write(IO_BASE + SEND_DESC_STRB, 32'h1, 2'd2);
    repeat (5) begin
      @(negedge clk);
      check_eq("data_desc_valid", data_desc_valid, 1'b1);
      check_eq("data_desc", data_desc, exp_desc);
      check_eq("dram_wr_addr", dram_wr_addr, exp_dram);
    end
    data_desc_ready = 1'b1;
    @(posedge clk);
    #2;
    check_eq("data_desc_valid", data_desc_valid, 1'b0);
    @(negedge clk);
    data_desc_ready = 1'b0;

    // Incoming descriptor
    @(negedge clk);
    in_desc = 64'h89AB_CDEF_0123_4567;
    in_desc_valid = 1'b1;
    bus_read(IO_BASE + RD_DESC_OFS, in_desc[31:0]);
    bus_read(IO_BASE + RD_DESC_OFS + 4, in_desc[63:32]);
    @(negedge clk);
    dbus_req = '{valid: 1'b1, wr: 1'b1, addr: IO_BASE + RD_DESC_STRB, wdata: 32'h1, size: 2'd0};
    #1;
    check_eq("in_desc_taken", in_desc_taken, 1'b1);
    @(negedge clk);
    dbus_req = '0;
    #1;
    check_eq("in_desc_taken", in_desc_taken, 1'b0);

    // DRAM flags, tag 0 never shows
    exp_flags = '0;
    tag_pulse(5'd0);
    tag_pulse(5'd3);
    tag_pulse(5'd7);
    tag_pulse(5'd12);
    tag_pulse(5'd31);
    exp_flags = flag_next(exp_flags, 32'h8000_1089, 32'h0);
    bus_write(IO_BASE + DRAM_FLAG_RST, 32'd7 << FLAG_IDX_LSB, 2'd2);
    exp_flags = flag_next(exp_flags, 32'h0, 32'h80);
    // Tag 20 lands in the same cycle as its clear
    tag_pulse(5'd20);
    dbus_req = '{valid: 1'b1, wr: 1'b1, addr: IO_BASE + DRAM_FLAG_RST,
                 wdata: 32'd20 << FLAG_IDX_LSB, size: 2'd2};
    @(negedge clk);
    dbus_req = '0;
    exp_flags = flag_next(exp_flags, 32'h0010_0000, 32'h0010_0000);
    repeat (3) @(negedge clk);
    bus_read(IO_BASE + RD_FLAGS_OFS, exp_flags);

    // Status with one input high at a time, then core ID
    bus_read(IO_BASE + RD_STAT_OFS, status_word(in_desc_valid, data_desc_ready));
    in_desc_valid = 1'b0;
    data_desc_ready = 1'b1;
    bus_read(IO_BASE + RD_STAT_OFS, status_word(in_desc_valid, data_desc_ready));
    bus_read(IO_BASE + RD_ID_OFS, {28'd0, core_id});

    repeat (4) @(negedge clk);
    $display("Checks: %0d, errors: %0d", checks, err_count);
    if (err_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/core_io_props.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol rules checked on the top level
module core_io_props #(
  parameter int ADDR_WIDTH = 16
) (
  input logic                clk,
  input logic                rst,
  input dbus_pkg::dbus_req_t dbus_req,
  input dbus_pkg::dbus_rsp_t dbus_rsp,
  input logic                ext_dmem_en,
  input io_map_pkg::desc_t   data_desc,
  input logic                data_desc_valid,
  input logic                data_desc_ready
);
  import dbus_pkg::*;

  logic io_read;

  assign io_read = dbus_req.valid && !dbus_req.wr && dbus_req.addr[ADDR_WIDTH-1];

  // Descriptor must not move under back-pressure
  desc_stable: assert property (@(posedge clk) disable iff (rst)
    (data_desc_valid && !data_desc_ready) |=> $stable(data_desc))
    else $error("data_desc changed while waiting for ready");

  io_read_rsp: assert property (@(posedge clk) disable iff (rst)
    io_read |=> dbus_rsp.valid)
    else $error("IO read without a response one cycle later");

  // IO window stays off the memory port
  no_mem_for_io: assert property (@(posedge clk) disable iff (rst)
    (dbus_req.valid && dbus_req.addr[ADDR_WIDTH-1]) |-> !ext_dmem_en)
    else $error("Memory enable raised for an IO address");

endmodule

bind core_io_top core_io_props #(.ADDR_WIDTH(ADDR_WIDTH)) i_core_io_props (.*);

`default_nettype wire

//--- verilog/core_io_top.sv
`timescale 1ns/1ps
`default_nettype none

// Data bus side of the core wrapper: memory lanes, IO registers, response merge
module core_io_top #(
  parameter int DATA_WIDTH    = 64,
  parameter int ADDR_WIDTH    = 16,
  parameter int CORE_ID_WIDTH = 4
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [CORE_ID_WIDTH-1:0]  core_id,

  input  dbus_pkg::dbus_req_t       dbus_req,
  output dbus_pkg::dbus_rsp_t       dbus_rsp,

  output logic                      ext_dmem_en,
  output logic [DATA_WIDTH/8-1:0]   ext_dmem_wen,
  output logic [ADDR_WIDTH-1:0]     ext_dmem_addr,
  output logic [DATA_WIDTH-1:0]     ext_dmem_wr_data,
  input  logic [DATA_WIDTH-1:0]     ext_dmem_rd_data,
  input  logic                      ext_dmem_rd_valid,

  input  io_map_pkg::desc_t         in_desc,
  input  logic                      in_desc_valid,
  output logic                      in_desc_taken,

  input  logic [4:0]                recv_dram_tag,
  input  logic                      recv_dram_tag_valid,

  output io_map_pkg::desc_t         data_desc,
  output logic                      data_desc_valid,
  output io_map_pkg::desc_t         dram_wr_addr,
  input  logic                      data_desc_ready
);
  import dbus_pkg::*;

  word_t mem_rdata;
  word_t io_rdata;
  logic  io_rsp;

  dmem_lane_adapter #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_dmem_lane_adapter (
    .clk              (clk),
    .rst              (rst),
    .dbus_req         (dbus_req),
    .ext_dmem_rd_data (ext_dmem_rd_data),
    .ext_dmem_en      (ext_dmem_en),
    .ext_dmem_wen     (ext_dmem_wen),
    .ext_dmem_addr    (ext_dmem_addr),
    .ext_dmem_wr_data (ext_dmem_wr_data),
    .mem_rdata        (mem_rdata)
  );

  io_regfile #(
    .ADDR_WIDTH    (ADDR_WIDTH),
    .CORE_ID_WIDTH (CORE_ID_WIDTH)
  ) i_io_regfile (
    .clk                 (clk),
    .rst                 (rst),
    .dbus_req            (dbus_req),
    .core_id             (core_id),
    .in_desc             (in_desc),
    .in_desc_valid       (in_desc_valid),
    .recv_dram_tag       (recv_dram_tag),
    .recv_dram_tag_valid (recv_dram_tag_valid),
    .data_desc_ready     (data_desc_ready),
    .io_rdata            (io_rdata),
    .io_rsp              (io_rsp),
    .in_desc_taken       (in_desc_taken),
    .data_desc           (data_desc),
    .data_desc_valid     (data_desc_valid),
    .dram_wr_addr        (dram_wr_addr)
  );

  dbus_responder i_dbus_responder (
    .clk               (clk),
    .rst               (rst),
    .mem_rdata         (mem_rdata),
    .ext_dmem_rd_valid (ext_dmem_rd_valid),
    .io_rdata          (io_rdata),
    .io_rsp            (io_rsp),
    .dbus_rsp          (dbus_rsp)
  );

endmodule

`default_nettype wire

//--- verilog/dbus_responder.sv
`timescale 1ns/1ps
`default_nettype none

// Merges memory and IO read data into the bus response
module dbus_responder (
  input  logic                clk,
  input  logic                rst,
  input  dbus_pkg::word_t     mem_rdata,
  input  logic                ext_dmem_rd_valid,
  input  dbus_pkg::word_t     io_rdata,
  input  logic                io_rsp,
  output dbus_pkg::dbus_rsp_t dbus_rsp
);
  import dbus_pkg::*;

  logic  rsp_valid;
  word_t rdata_sel;
  word_t last_rdata;

  assign rsp_valid = io_rsp || ext_dmem_rd_valid;
  // IO word has priority
  assign rdata_sel = io_rsp ? io_rdata : mem_rdata;

  // Keeps the data lines quiet between responses
  always_ff @(posedge clk) begin
    if (rst) begin
      last_rdata <= '0;
    end else if (rsp_valid) begin
      last_rdata <= rdata_sel;
    end
  end

  always_comb begin
    dbus_rsp.valid = rsp_valid;
    dbus_rsp.rdata = rsp_valid ? rdata_sel : last_rdata;
  end

endmodule

`default_nettype wire

//--- dmem_port/dmem_lane_adapter.sv
`timescale 1ns/1ps
`default_nettype none

// 32-bit bus words onto a wider external data memory line
module dmem_lane_adapter #(
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  dbus_pkg::dbus_req_t      dbus_req,
  input  logic [DATA_WIDTH-1:0]    ext_dmem_rd_data,
  output logic                     ext_dmem_en,
  output logic [DATA_WIDTH/8-1:0]  ext_dmem_wen,
  output logic [ADDR_WIDTH-1:0]    ext_dmem_addr,
  output logic [DATA_WIDTH-1:0]    ext_dmem_wr_data,
  output dbus_pkg::word_t          mem_rdata
);
  import dbus_pkg::*;

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int LANES      = DATA_WIDTH / 32;
  localparam int LANE_BITS  = (LANES > 1) ? $clog2(LANES) : 1;

  logic                 mem_sel;
  logic [BUS_BYTES-1:0] strb;

  // Top address bit clear selects memory
  assign mem_sel = dbus_req.valid && !dbus_req.addr[ADDR_WIDTH-1];

  assign strb = word_strb(mem_sel, dbus_req.wr, dbus_req.size, dbus_req.addr[1:0]);

  assign ext_dmem_en   = mem_sel;
  assign ext_dmem_addr = dbus_req.addr[ADDR_WIDTH-1:0];

  if (LANES == 1) begin : g_narrow
    // Memory as wide as the bus
    assign ext_dmem_wen     = strb;
    assign ext_dmem_wr_data = dbus_req.wdata;
    assign mem_rdata        = ext_dmem_rd_data;
  end else begin : g_wide
    logic [LANE_BITS-1:0] lane;
    logic [LANE_BITS-1:0] rd_lane_q;

    // Word position inside the memory line
    assign lane = dbus_req.addr[LANE_BITS+1:2];

    assign ext_dmem_wen     = STRB_WIDTH'(strb) << {lane, 2'b00};
    assign ext_dmem_wr_data = DATA_WIDTH'(dbus_req.wdata) << {lane, 5'd0};

    // Memory answers one cycle later, remember the lane for the return path
    always_ff @(posedge clk) begin
      if (rst) begin
        rd_lane_q <= '0;
      end else if (mem_sel && !dbus_req.wr) begin
        rd_lane_q <= lane;
      end
    end

    assign mem_rdata = ext_dmem_rd_data[rd_lane_q*32 +: 32];
  end

endmodule

`default_nettype wire

//--- io_regs/io_regfile.sv
`timescale 1ns/1ps
`default_nettype none

// Memory-mapped IO registers of the core
module io_regfile #(
  parameter int ADDR_WIDTH    = 16,
  parameter int CORE_ID_WIDTH = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  dbus_pkg::dbus_req_t      dbus_req,
  input  logic [CORE_ID_WIDTH-1:0] core_id,
  input  io_map_pkg::desc_t        in_desc,
  input  logic                     in_desc_valid,
  input  logic [4:0]               recv_dram_tag,
  input  logic                     recv_dram_tag_valid,
  input  logic                     data_desc_ready,
  output dbus_pkg::word_t          io_rdata,
  output logic                     io_rsp,
  output logic                     in_desc_taken,
  output io_map_pkg::desc_t        data_desc,
  output logic                     data_desc_valid,
  output io_map_pkg::desc_t        dram_wr_addr
);
  import dbus_pkg::*;
  import io_map_pkg::*;

  logic                 io_wr;
  logic                 io_rd;
  logic [6:0]           ofs;
  logic [BUS_BYTES-1:0] strb;
  logic [7:0]           byte_mask;
  desc_t                wide_wdata;
  logic                 strb_set;
  logic                 desc_wen;
  logic                 dram_addr_wen;
  logic                 send_desc;
  logic                 flag_clr;
  logic [4:0]           clr_idx;
  logic [4:0]           tag_q;
  logic                 tag_valid_q;
  logic [31:0]          dram_flags;
  status_t              status;

  assign io_wr = dbus_req.valid && dbus_req.addr[ADDR_WIDTH-1] && dbus_req.wr;
  assign io_rd = dbus_req.valid && dbus_req.addr[ADDR_WIDTH-1] && !dbus_req.wr;
  assign ofs   = dbus_req.addr[6:0];

  //////////////////////////////////////////////////
  // Writes

  // Word mask moved into the upper or lower half of a 64-bit register
  assign strb       = word_strb(dbus_req.valid, dbus_req.wr, dbus_req.size, dbus_req.addr[1:0]);
  assign byte_mask  = {4'd0, strb} << {dbus_req.addr[2], 2'b00};
  assign wide_wdata = {dbus_req.wdata, dbus_req.wdata};

  // Byte stores arrive replicated on all lanes, so bit 0 holds the strobe
  assign strb_set = dbus_req.wdata[0];

  // No descriptor update while one is waiting for the consumer
  assign desc_wen      = io_wr && (ofs[6:3] == SEND_DESC_OFS[6:3]) && !data_desc_valid;
  assign dram_addr_wen = io_wr && (ofs[6:3] == DRAM_ADDR_OFS[6:3]);

  assign send_desc     = io_wr && (ofs == SEND_DESC_STRB) && strb_set;
  assign in_desc_taken = io_wr && (ofs == RD_DESC_STRB) && strb_set;
  assign flag_clr      = io_wr && (ofs == DRAM_FLAG_RST);
  assign clr_idx       = dbus_req.wdata[FLAG_IDX_LSB +: 5];

  io_byte_reg #(.payload_t(desc_t)) i_desc_reg (
    .clk       (clk),
    .wen       (desc_wen),
    .byte_mask (byte_mask),
    .wdata     (wide_wdata),
    .q         (data_desc)
  );

  io_byte_reg #(.payload_t(desc_t)) i_dram_addr_reg (
    .clk       (clk),
    .wen       (dram_addr_wen),
    .byte_mask (byte_mask),
    .wdata     (wide_wdata),
    .q         (dram_wr_addr)
  );

  // Outgoing descriptor handshake, acceptance wins over a new send
  always_ff @(posedge clk) begin
    if (rst) begin
      data_desc_valid <= 1'b0;
    end else if (data_desc_valid && data_desc_ready) begin
      data_desc_valid <= 1'b0;
    end else if (send_desc) begin
      data_desc_valid <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // DRAM receive flags

  // Tag input registered once for timing
  always_ff @(posedge clk) begin
    tag_q <= recv_dram_tag;
    if (rst) begin
      tag_valid_q <= 1'b0;
    end else begin
      tag_valid_q <= recv_dram_tag_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dram_flags <= '0;
    end else begin
      if (flag_clr) begin
        dram_flags[clr_idx] <= 1'b0;
      end
      // A set on the same bit beats the clear
      if (tag_valid_q) begin
        dram_flags[tag_q] <= 1'b1;
      end
      dram_flags[0] <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Reads

  always_comb begin
    status                 = '0;
    status.in_desc_valid   = in_desc_valid;
    status.data_desc_ready = data_desc_ready;
  end

  // Read word, held when a descriptor read finds nothing valid
  always_ff @(posedge clk) begin
    if (io_rd) begin
      if (ofs[6:3] == RD_DESC_OFS[6:3]) begin
        if (in_desc_valid) begin
          io_rdata <= dbus_req.addr[2] ? in_desc[63:32] : in_desc[31:0];
        end
      end else if (ofs[6:2] == RD_FLAGS_OFS[6:2]) begin
        io_rdata <= dram_flags;
      end else if (ofs[6:2] == RD_STAT_OFS[6:2]) begin
        io_rdata <= word_t'(status);
      end else if (ofs[6:2] == RD_ID_OFS[6:2]) begin
        io_rdata <= word_t'(core_id);
      end else begin
        io_rdata <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      io_rsp <= 1'b0;
    end else begin
      io_rsp <= io_rd;
    end
  end

endmodule

`default_nettype wire

//--- io_regs/io_byte_reg.sv
`timescale 1ns/1ps
`default_nettype none

// Register with per-byte write enables
module io_byte_reg #(
  parameter type payload_t = logic [63:0]
) (
  input  logic                         clk,
  input  logic                         wen,
  input  logic [$bits(payload_t)/8-1:0] byte_mask,
  input  payload_t                     wdata,
  output payload_t                     q
);

  localparam int NBYTES = $bits(payload_t) / 8;

  always_ff @(posedge clk) begin
    if (wen) begin
      for (int i = 0; i < NBYTES; i++) begin
        if (byte_mask[i]) begin
          q[i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- common/io_map_pkg.sv
`default_nettype none

// Memory-mapped IO layout, offsets inside the IO window
package io_map_pkg;

  //////////////////////////////////////////////////
  // Write side

  // 8-byte registers, decoded on offset bits 6:3
  localparam logic [6:0] SEND_DESC_OFS = 7'h00;
  localparam logic [6:0] DRAM_ADDR_OFS = 7'h08;

  // Strobes, exact offset match, data bit 0 qualifies
  localparam logic [6:0] SEND_DESC_STRB = 7'h38;
  localparam logic [6:0] RD_DESC_STRB   = 7'h39;
  localparam logic [6:0] DRAM_FLAG_RST  = 7'h3A;

  // Flag index position in the clear write
  localparam int FLAG_IDX_LSB = 16;

  //////////////////////////////////////////////////
  // Read side

  // Two words of the incoming descriptor
  localparam logic [6:0] RD_DESC_OFS  = 7'h40;
  // Single words, decoded on offset bits 6:2
  localparam logic [6:0] RD_FLAGS_OFS = 7'h48;
  localparam logic [6:0] RD_STAT_OFS  = 7'h4C;
  localparam logic [6:0] RD_ID_OFS    = 7'h50;

  typedef logic [63:0] desc_t;

  typedef struct packed {
    logic [22:0] rsvd_hi;
    logic        data_desc_ready;
    logic [6:0]  rsvd_lo;
    logic        in_desc_valid;
  } status_t;

endpackage

`default_nettype wire

//--- common/dbus_pkg.sv
`default_nettype none

// Data bus types shared by the core wrapper and its testbench
package dbus_pkg;

  localparam int BUS_BYTES = 4;

  // Request size encoding
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  typedef logic [8*BUS_BYTES-1:0] word_t;

  typedef struct packed {
    logic        valid;
    logic        wr;
    logic [31:0] addr;
    word_t       wdata;
    logic [1:0]  size;
  } dbus_req_t;

  typedef struct packed {
    logic  valid;
    word_t rdata;
  } dbus_rsp_t;

  // Byte enables inside one bus word, zero for reads
  function automatic logic [BUS_BYTES-1:0] word_strb(input logic       valid,
                                                     input logic       wr,
                                                     input logic [1:0] size,
                                                     input logic [1:0] addr_lo);
    logic [BUS_BYTES-1:0] mask;
    case (size)
      SIZE_BYTE: mask = 4'b0001 << addr_lo;
      SIZE_HALF: mask = 4'b0011 << addr_lo;
      default:   mask = 4'b1111;
    endcase
    if (!valid || !wr) begin
      mask = '0;
    end
    return mask;
  endfunction

endpackage

`default_nettype wire
